//--- verilog/idecode_defines.svh
// instruction decode field and bit definitions
`ifndef IDECODE_DEFINES_SVH
`define IDECODE_DEFINES_SVH

// opcode field positions
`define OP_BASE_MSB     7
`define OP_BASE_LSB     5
`define OP_IMM_BIT      4       // alu immediate form
`define OP_PTR0_MSB     3
`define OP_PTR0_LSB     2
`define OP_PTR1_MSB     1       // source 1 and destination
`define OP_PTR1_LSB     0
`define OP_LDST_MSB     4
`define OP_LDST_LSB     3
`define OP_AHI_MSB      2       // address bits 10:8
`define OP_AHI_LSB      0
`define OP_GRP_MSB      4
`define OP_GRP_LSB      3
`define OP_MISC_MSB     2
`define OP_MISC_LSB     0

// base operations
`define BASE_CTRL       3'd0
`define BASE_ADD        3'd1
`define BASE_SUB        3'd2
`define BASE_AND        3'd3
`define BASE_OR         3'd4
`define BASE_XOR        3'd5
`define BASE_LD         3'd6
`define BASE_ST         3'd7

// control groups, 2 and 3 illegal
`define GRP_MISC        2'd0
`define GRP_JMP         2'd1

// misc operations, 5 to 7 illegal
`define MISC_NOP        3'd0
`define MISC_HALT       3'd1
`define MISC_SET_BCZ    3'd2
`define MISC_SET_BCNZ   3'd3
`define MISC_CLR_BC     3'd4

// control register and status bits
`define CR_BCZ_BIT      0
`define CR_BCNZ_BIT     1
`define SR_OVF_BIT      0
`define SR_NZ_BIT       2
`define SR_Z_BIT        3

`endif

//--- verilog/idecode_pkg.sv
// instruction decode types
package idecode_pkg;

    // one byte from fetch
    typedef logic [7:0] inst_t;

    // second byte of a two byte instruction
    typedef logic [7:0] imm_t;

    // register file select, four registers
    typedef logic [1:0] reg_ptr_t;

    // data or jump address, opcode high bits + immediate
    typedef logic [10:0] addr_t;

    // operation handed to execute
    typedef enum logic [3:0] {
        EXEC_NOP = 4'd0,
        ALU_ADD  = 4'd1,
        ALU_SUB  = 4'd2,
        ALU_AND  = 4'd3,
        ALU_OR   = 4'd4,
        ALU_XOR  = 4'd5,
        MEM_RD   = 4'd6,
        MEM_WR   = 4'd7,
        CPU_JMP  = 4'd8
    } exec_ctrl_e;

    // byte assembler state
    typedef enum logic {
        ASM_OPCODE = 1'b0,      // waiting for an opcode
        ASM_IMM    = 1'b1       // opcode held, waiting for its immediate
    } asm_state_e;

endpackage

//--- verilog/inst_assembler.sv
// instruction byte assembler
`timescale 1ns/1ns

`include "idecode_defines.svh"

module inst_assembler (
    input  logic                clk,
    input  logic                reset_,
    input  idecode_pkg::inst_t  inst,
    input  logic                inst_vld,
    output logic                asm_vld,
    output idecode_pkg::inst_t  asm_op,
    output idecode_pkg::imm_t   asm_imm
);

    idecode_pkg::asm_state_e state;
    logic                    needs_imm;

    // which opcodes carry a second byte
    always_comb begin
        case (inst[`OP_BASE_MSB:`OP_BASE_LSB])
            `BASE_CTRL: needs_imm = (inst[`OP_GRP_MSB:`OP_GRP_LSB] == `GRP_JMP);
            `BASE_LD,
            `BASE_ST:   needs_imm = 1'b1;
            default:    needs_imm = inst[`OP_IMM_BIT];     // alu ops
        endcase
    end

    always_ff @(posedge clk) begin
        if (!reset_) begin
            state   <= idecode_pkg::ASM_OPCODE;
            asm_vld <= 1'b0;
        end else begin
            asm_vld <= 1'b0;                    // single cycle pulse
            if (inst_vld) begin
                case (state)
                    idecode_pkg::ASM_OPCODE: begin
                        if (needs_imm) begin
                            state <= idecode_pkg::ASM_IMM;
                        end else begin
                            asm_vld <= 1'b1;
                        end
                    end
                    idecode_pkg::ASM_IMM: begin
                        asm_vld <= 1'b1;
                        state   <= idecode_pkg::ASM_OPCODE;
                    end
                    default: state <= idecode_pkg::ASM_OPCODE;
                endcase
            end
        end
    end

    // opcode is held in asm_op until its immediate shows up
    always_ff @(posedge clk) begin
        if (inst_vld) begin
            if (state == idecode_pkg::ASM_OPCODE) begin
                asm_op  <= inst;
                asm_imm <= '0;
            end else begin
                asm_imm <= inst;
            end
        end
    end

endmodule

//--- verilog/op_decoder.sv
// instruction decoder with branch condition and halt
`timescale 1ns/1ns

`include "idecode_defines.svh"

module op_decoder (
    input  logic                     clk,
    input  logic                     reset_,
    input  logic                     asm_vld,
    input  idecode_pkg::inst_t       asm_op,
    input  idecode_pkg::imm_t        asm_imm,
    input  logic [7:0]               sr,
    output logic                     exec_en,
    output idecode_pkg::exec_ctrl_e  exec_ctrl,
    output idecode_pkg::reg_ptr_t    src0,
    output logic                     src0_rd_en,
    output idecode_pkg::reg_ptr_t    src1,
    output logic                     src1_rd_en,
    output idecode_pkg::reg_ptr_t    dst,
    output idecode_pkg::imm_t        imm_val,
    output logic                     imm_vld,
    output idecode_pkg::addr_t       addr,
    output logic [1:0]               bc_mode,
    output logic                     halted,
    output logic                     fetch_en
);

    logic [2:0]              base_op;
    logic [1:0]              ctrl_grp;
    logic [2:0]              misc_op;
    idecode_pkg::reg_ptr_t   ptr0;
    idecode_pkg::reg_ptr_t   ptr1;
    idecode_pkg::reg_ptr_t   ldst_reg;
    idecode_pkg::addr_t      op_addr;
    logic                    decode;
    logic                    jmp_taken;

    idecode_pkg::exec_ctrl_e exec_ctrl_nxt;
    idecode_pkg::reg_ptr_t   src0_nxt;
    idecode_pkg::reg_ptr_t   src1_nxt;
    idecode_pkg::reg_ptr_t   dst_nxt;
    idecode_pkg::imm_t       imm_val_nxt;
    idecode_pkg::addr_t      addr_nxt;
    logic                    src0_rd_en_nxt;
    logic                    src1_rd_en_nxt;
    logic                    imm_vld_nxt;
    logic [1:0]              bc_mode_nxt;
    logic                    halted_nxt;

    function automatic idecode_pkg::exec_ctrl_e alu_ctrl(input logic [2:0] op);
        case (op)
            `BASE_ADD: return idecode_pkg::ALU_ADD;
            `BASE_SUB: return idecode_pkg::ALU_SUB;
            `BASE_AND: return idecode_pkg::ALU_AND;
            `BASE_OR:  return idecode_pkg::ALU_OR;
            `BASE_XOR: return idecode_pkg::ALU_XOR;
            default:   return idecode_pkg::EXEC_NOP;
        endcase
    endfunction

    assign base_op  = asm_op[`OP_BASE_MSB:`OP_BASE_LSB];
    assign ctrl_grp = asm_op[`OP_GRP_MSB:`OP_GRP_LSB];
    assign misc_op  = asm_op[`OP_MISC_MSB:`OP_MISC_LSB];
    assign ptr0     = asm_op[`OP_PTR0_MSB:`OP_PTR0_LSB];
    assign ptr1     = asm_op[`OP_PTR1_MSB:`OP_PTR1_LSB];
    assign ldst_reg = asm_op[`OP_LDST_MSB:`OP_LDST_LSB];
    assign op_addr  = {asm_op[`OP_AHI_MSB:`OP_AHI_LSB], asm_imm};
    assign decode   = asm_vld & ~halted;     // drop everything after halt

    // branch condition from bc_mode and status
    always_comb begin
        case ({bc_mode[`CR_BCNZ_BIT], bc_mode[`CR_BCZ_BIT]})
            2'b11:   jmp_taken = sr[`SR_OVF_BIT];
            2'b01:   jmp_taken = sr[`SR_Z_BIT];
            2'b10:   jmp_taken = sr[`SR_NZ_BIT];
            default: jmp_taken = 1'b1;          // unconditional
        endcase
    end

    always_comb begin
        exec_ctrl_nxt  = exec_ctrl;
        src0_nxt       = src0;
        src1_nxt       = src1;
        dst_nxt        = dst;
        imm_val_nxt    = imm_val;
        addr_nxt       = addr;
        src0_rd_en_nxt = 1'b0;
        src1_rd_en_nxt = 1'b0;
        imm_vld_nxt    = 1'b0;
        bc_mode_nxt    = bc_mode;
        halted_nxt     = halted;

        if (decode) begin
            exec_ctrl_nxt = idecode_pkg::EXEC_NOP;
            case (base_op)
                `BASE_CTRL: begin
                    if (ctrl_grp == `GRP_JMP) begin
                        addr_nxt = op_addr;     // jump target
                        if (jmp_taken) begin
                            exec_ctrl_nxt = idecode_pkg::CPU_JMP;
                        end
                    end else if (ctrl_grp == `GRP_MISC) begin
                        case (misc_op)
                            `MISC_HALT:     halted_nxt = 1'b1;
                            `MISC_SET_BCZ:  bc_mode_nxt[`CR_BCZ_BIT] = 1'b1;
                            `MISC_SET_BCNZ: bc_mode_nxt[`CR_BCNZ_BIT] = 1'b1;
                            `MISC_CLR_BC:   bc_mode_nxt = 2'b00;
                            default:        ;       // nop and illegal codes
                        endcase
                    end
                end
                `BASE_LD: begin
                    exec_ctrl_nxt = idecode_pkg::MEM_RD;
                    dst_nxt       = ldst_reg;
                    addr_nxt      = op_addr;
                end
                `BASE_ST: begin
                    exec_ctrl_nxt  = idecode_pkg::MEM_WR;
                    src0_nxt       = ldst_reg;
                    src0_rd_en_nxt = 1'b1;
                    addr_nxt       = op_addr;
                end
                default: begin
                    exec_ctrl_nxt  = alu_ctrl(base_op);
                    src0_nxt       = ptr0;
                    src0_rd_en_nxt = 1'b1;
                    dst_nxt        = ptr1;
                    if (asm_op[`OP_IMM_BIT]) begin
                        imm_val_nxt = asm_imm;
                        imm_vld_nxt = 1'b1;
                    end else begin
                        src1_nxt       = ptr1;
                        src1_rd_en_nxt = 1'b1;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (!reset_) begin
            exec_en    <= 1'b0;
            exec_ctrl  <= idecode_pkg::EXEC_NOP;
            src0       <= '0;
            src0_rd_en <= 1'b0;
            src1       <= '0;
            src1_rd_en <= 1'b0;
            dst        <= '0;
            imm_val    <= '0;
            imm_vld    <= 1'b0;
            addr       <= '0;
            bc_mode    <= 2'b00;
            halted     <= 1'b0;
            fetch_en   <= 1'b1;
        end else begin
            exec_en    <= decode;
            exec_ctrl  <= exec_ctrl_nxt;
            src0       <= src0_nxt;
            src0_rd_en <= src0_rd_en_nxt;
            src1       <= src1_nxt;
            src1_rd_en <= src1_rd_en_nxt;
            dst        <= dst_nxt;
            imm_val    <= imm_val_nxt;
            imm_vld    <= imm_vld_nxt;
            addr       <= addr_nxt;
            bc_mode    <= bc_mode_nxt;
            halted     <= halted_nxt;       // sticky
            fetch_en   <= ~halted_nxt;
        end
    end

endmodule

//--- verilog/idecode_top.sv
// two stage instruction decode top
`timescale 1ns/1ns

module idecode_top (
    input  logic                     clk,
    input  logic                     reset_,
    input  idecode_pkg::inst_t       inst,
    input  logic                     inst_vld,
    input  logic [7:0]               sr,
    output logic                     exec_en,
    output idecode_pkg::exec_ctrl_e  exec_ctrl,
    output idecode_pkg::reg_ptr_t    src0,
    output logic                     src0_rd_en,
    output idecode_pkg::reg_ptr_t    src1,
    output logic                     src1_rd_en,
    output idecode_pkg::reg_ptr_t    dst,
    output idecode_pkg::imm_t        imm_val,
    output logic                     imm_vld,
    output idecode_pkg::addr_t       addr,
    output logic [1:0]               bc_mode,
    output logic                     halted,
    output logic                     fetch_en
);

    logic               asm_vld;    // one pulse per instruction
    idecode_pkg::inst_t asm_op;
    idecode_pkg::imm_t  asm_imm;

    inst_assembler u_inst_assembler (
        .clk        (clk),
        .reset_     (reset_),
        .inst       (inst),
        .inst_vld   (inst_vld),
        .asm_vld    (asm_vld),
        .asm_op     (asm_op),
        .asm_imm    (asm_imm)
    );

    op_decoder u_op_decoder (
        .clk        (clk),
        .reset_     (reset_),
        .asm_vld    (asm_vld),
        .asm_op     (asm_op),
        .asm_imm    (asm_imm),
        .sr         (sr),
        .exec_en    (exec_en),
        .exec_ctrl  (exec_ctrl),
        .src0       (src0),
        .src0_rd_en (src0_rd_en),
        .src1       (src1),
        .src1_rd_en (src1_rd_en),
        .dst        (dst),
        .imm_val    (imm_val),
        .imm_vld    (imm_vld),
        .addr       (addr),
        .bc_mode    (bc_mode),
        .halted     (halted),
        .fetch_en   (fetch_en)
    );

endmodule

//--- sim/idecode_checker.sv
// decode output assertions
`timescale 1ns/1ns

module idecode_checker (
    input logic clk,
    input logic reset_,
    input logic exec_en,
    input logic imm_vld,
    input logic src1_rd_en,
    input logic halted,
    input logic fetch_en
);

    int unsigned fail_count = 0;

    // immediate replaces the second source
    imm_src1_excl: assert property (@(posedge clk) disable iff (!reset_)
        !(imm_vld && src1_rd_en))
        else begin
            fail_count++;
            $error("imm_vld and src1_rd_en high together");
        end

    halt_sticky: assert property (@(posedge clk) disable iff (!reset_)
        halted |=> halted)
        else begin
            fail_count++;
            $error("halted dropped after being set");
        end

    halt_fetch_off: assert property (@(posedge clk) disable iff (!reset_)
        halted |-> !fetch_en)
        else begin
            fail_count++;
            $error("fetch_en high while halted");
        end

    // only the halt itself may carry exec_en
    no_exec_after_halt: assert property (@(posedge clk) disable iff (!reset_)
        halted |=> !exec_en)
        else begin
            fail_count++;
            $error("exec_en after halt");
        end

endmodule

bind idecode_top idecode_checker u_checker (
    .clk        (clk),
    .reset_     (reset_),
    .exec_en    (exec_en),
    .imm_vld    (imm_vld),
    .src1_rd_en (src1_rd_en),
    .halted     (halted),
    .fetch_en   (fetch_en)
);

//--- sim/idecode_tb.sv
// instruction decode testbench
`timescale 1ns/1ns

`include "idecode_defines.svh"

module idecode_tb;

    logic                     clk = 1'b0;
    logic                     reset_;
    idecode_pkg::inst_t       inst;
    logic                     inst_vld;
    logic [7:0]               sr;
    logic                     exec_en;
    idecode_pkg::exec_ctrl_e  exec_ctrl;
    idecode_pkg::reg_ptr_t    src0;
    logic                     src0_rd_en;
    idecode_pkg::reg_ptr_t    src1;
    logic                     src1_rd_en;
    idecode_pkg::reg_ptr_t    dst;
    idecode_pkg::imm_t        imm_val;
    logic                     imm_vld;
    idecode_pkg::addr_t       addr;
    logic [1:0]               bc_mode;
    logic                     halted;
    logic                     fetch_en;

    // golden records, one entry per data line
    string       g_name[$];
    int          g_count[$];
    logic [31:0] g_b0[$];
    logic [31:0] g_b1[$];
    logic [31:0] g_sr[$];
    logic [31:0] g_ctrl[$];
    logic [31:0] g_src0[$];
    logic [31:0] g_s0en[$];
    logic [31:0] g_src1[$];
    logic [31:0] g_s1en[$];
    logic [31:0] g_dst[$];
    logic [31:0] g_imm[$];
    logic [31:0] g_ivld[$];
    logic [31:0] g_addr[$];
    logic [31:0] g_bc[$];

    int          exp_q[$];              // indices of instructions in flight
    int          errors = 0;
    int          cycles = 0;
    int          limit = 0;
    logic [15:0] lfsr_state = 16'd58951;

    always #50 clk = ~clk;

    idecode_top DUT (
        .clk        (clk),
        .reset_     (reset_),
        .inst       (inst),
        .inst_vld   (inst_vld),
        .sr         (sr),
        .exec_en    (exec_en),
        .exec_ctrl  (exec_ctrl),
        .src0       (src0),
        .src0_rd_en (src0_rd_en),
        .src1       (src1),
        .src1_rd_en (src1_rd_en),
        .dst        (dst),
        .imm_val    (imm_val),
        .imm_vld    (imm_vld),
        .addr       (addr),
        .bc_mode    (bc_mode),
        .halted     (halted),
        .fetch_en   (fetch_en)
    );

    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 16'hB400;     // galois taps 16,14,13,11
        end
        return s >> 1;
    endfunction

    function automatic bit is_jump(input logic [7:0] b);
        return (b[`OP_BASE_MSB:`OP_BASE_LSB] == `BASE_CTRL) &&
               (b[`OP_GRP_MSB:`OP_GRP_LSB] == `GRP_JMP);
    endfunction

    function automatic bit is_halt(input logic [7:0] b);
        return (b[`OP_BASE_MSB:`OP_BASE_LSB] == `BASE_CTRL) &&
               (b[`OP_GRP_MSB:`OP_GRP_LSB] == `GRP_MISC) &&
               (b[`OP_MISC_MSB:`OP_MISC_LSB] == `MISC_HALT);
    endfunction

    task check_value(input string test, input string field,
                     input logic [31:0] exp, input logic [31:0] act);
        if (act !== exp) begin
            errors++;
            $display("ERR %s %s expected %0h actual %0h", test, field, exp, act);
        end
    endtask

    task load_golden();
        int          fd;
        int          cnt;
        int          nb;
        string       line;
        string       tname;
        logic [127:0] name_buf;
        logic [31:0] f[13];
        fd = $fopen("sim/idecode_golden.txt", "r");
        if (fd == 0) begin
            errors++;
            $display("cannot open the golden file");
        end else begin
            while ($fgets(line, fd) != 0) begin
                if (line.len() < 2 || line.substr(0, 0) == "#") begin
                    continue;                           // comment or blank
                end
                cnt = $sscanf(line, "%s %d %h %h %h %h %h %h %h %h %h %h %h %h %h",
                              name_buf, nb, f[0], f[1], f[2], f[3], f[4], f[5],
                              f[6], f[7], f[8], f[9], f[10], f[11], f[12]);
                if (cnt != 15) begin
                    errors++;
                    $display("golden line could not be parsed: %s", line);
                end else begin
                    tname = $sformatf("%0s", name_buf);
                    g_name.push_back(tname);
                    g_count.push_back(nb);
                    g_b0.push_back(f[0]);
                    g_b1.push_back(f[1]);
                    g_sr.push_back(f[2]);
                    g_ctrl.push_back(f[3]);
                    g_src0.push_back(f[4]);
                    g_s0en.push_back(f[5]);
                    g_src1.push_back(f[6]);
                    g_s1en.push_back(f[7]);
                    g_dst.push_back(f[8]);
                    g_imm.push_back(f[9]);
                    g_ivld.push_back(f[10]);
                    g_addr.push_back(f[11]);
                    g_bc.push_back(f[12]);
                end
            end
            $fclose(fd);
        end
    endtask

    task send_byte(input logic [7:0] b);
        @(negedge clk);
        inst     = b;
        inst_vld = 1'b1;
    endtask

    task idle_cycles(input int n);
        repeat (n) begin
            @(negedge clk);
            inst_vld = 1'b0;
        end
    endtask

    // two lfsr bits give a gap of 0 to 3 cycles
    task random_gap(output int gap);
        int i;
        gap = 0;
        for (i = 0; i < 2; i++) begin
            gap        = gap * 2 + (lfsr_state[0] ? 1 : 0);
            lfsr_state = lfsr_step(lfsr_state);
        end
    endtask

    task wait_pipe_empty();
        @(negedge clk);
        inst_vld = 1'b0;
        do begin
            @(posedge clk);
        end while (exp_q.size() != 0);
    endtask

    task run_line(input int i);
        int gap;
        if (is_jump(g_b0[i][7:0])) begin
            wait_pipe_empty();              // sr held steady for this jump
            @(negedge clk);
            sr = g_sr[i][7:0];
        end
        exp_q.push_back(i);
        send_byte(g_b0[i][7:0]);
        if (g_count[i] == 2) begin
            random_gap(gap);
            idle_cycles(gap);
            send_byte(g_b1[i][7:0]);
        end
    endtask

    task watch_outputs();
        int idx;
        bit halt_item;
        forever begin
            @(negedge clk);
            if (exec_en) begin
                if (exp_q.size() == 0) begin
                    errors++;
                    $display("exec_en came with no instruction expected");
                end else begin
                    idx = exp_q.pop_front();
                    halt_item = is_halt(g_b0[idx][7:0]);
                    check_value(g_name[idx], "exec_ctrl", g_ctrl[idx], 32'(exec_ctrl));
                    check_value(g_name[idx], "src0", g_src0[idx], 32'(src0));
                    check_value(g_name[idx], "src0_rd_en", g_s0en[idx], 32'(src0_rd_en));
                    check_value(g_name[idx], "src1", g_src1[idx], 32'(src1));
                    check_value(g_name[idx], "src1_rd_en", g_s1en[idx], 32'(src1_rd_en));
                    check_value(g_name[idx], "dst", g_dst[idx], 32'(dst));
                    check_value(g_name[idx], "imm_val", g_imm[idx], 32'(imm_val));
                    check_value(g_name[idx], "imm_vld", g_ivld[idx], 32'(imm_vld));
                    check_value(g_name[idx], "addr", g_addr[idx], 32'(addr));
                    check_value(g_name[idx], "bc_mode", g_bc[idx], 32'(bc_mode));
                    check_value(g_name[idx], "halted", 32'(halt_item), 32'(halted));
                    check_value(g_name[idx], "fetch_en", 32'(!halt_item), 32'(fetch_en));
                end
            end
        end
    endtask

    // run limit
    always @(posedge clk) begin
        cycles = cycles + 1;
        if (limit > 0 && cycles > limit) begin
            $display("timeout after %0d cycles, decode results did not arrive", cycles);
            $display("Simulation failed");
            $finish;
        end
    end

    initial begin
        int i;
        reset_   = 1'b0;
        inst     = '0;
        inst_vld = 1'b0;
        sr       = '0;
        load_golden();
        limit = g_name.size() * 8 + 50;
        if (g_name.size() == 0) begin
            errors++;
            $display("no golden records were loaded");
        end
        repeat (10) @(posedge clk);
        @(negedge clk);
        reset_ = 1'b1;
        fork
            watch_outputs();
        join_none
        for (i = 0; i < g_name.size(); i++) begin
            run_line(i);
        end
        // bytes after halt must be dropped
        send_byte(8'h26);
        send_byte(8'h38);
        send_byte(8'h5A);
        send_byte(8'h0A);
        wait_pipe_empty();
        idle_cycles(4);
        check_value("halt_tail", "halted", 32'd1, 32'(halted));
        check_value("halt_tail", "fetch_en", 32'd0, 32'(fetch_en));
        if (exp_q.size() != 0) begin
            errors++;
            $display("%0d instructions never reached execute", exp_q.size());
        end
        $display("errors: %0d checks, %0d assertions", errors, DUT.u_checker.fail_count);
        if (errors == 0 && DUT.u_checker.fail_count == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

//--- sim/idecode_golden.txt
# name bytes byte0 byte1 sr exec_ctrl src0 src0_rd_en src1 src1_rd_en dst imm_val imm_vld addr bc_mode
# all hex except bytes; exec_ctrl 0 nop, 1-5 alu, 6 mem rd, 7 mem wr, 8 jmp
add_reg    1 26 00 00 1 1 1 2 1 2 00 0 000 0
sub_reg    1 4C 00 00 2 3 1 0 1 0 00 0 000 0
and_reg    1 6B 00 00 3 2 1 3 1 3 00 0 000 0
or_reg     1 81 00 00 4 0 1 1 1 1 00 0 000 0
xor_reg    1 A5 00 00 5 1 1 1 1 1 00 0 000 0
add_imm    2 38 5A 00 1 2 1 1 0 0 5A 1 000 0
sub_imm    2 53 C3 00 2 0 1 1 0 3 C3 1 000 0
and_imm    2 7E 0F 00 3 3 1 1 0 2 0F 1 000 0
or_imm     2 94 F0 00 4 1 1 1 0 0 F0 1 000 0
xor_imm    2 B9 A5 00 5 2 1 1 0 1 A5 1 000 0
ld         2 D5 3C 00 6 2 0 1 0 2 A5 0 53C 0
st         2 EB 81 00 7 1 1 1 0 2 A5 0 381 0
jmp_always 2 0A 44 00 8 1 0 1 0 2 A5 0 244 0
set_bcz    1 02 00 00 0 1 0 1 0 2 A5 0 244 1
jz_taken   2 09 10 08 8 1 0 1 0 2 A5 0 110 1
jz_not     2 0E 20 04 0 1 0 1 0 2 A5 0 620 1
clr_bc     1 04 00 00 0 1 0 1 0 2 A5 0 620 0
set_bcnz   1 03 00 00 0 1 0 1 0 2 A5 0 620 2
jnz_taken  2 0F FF 04 8 1 0 1 0 2 A5 0 7FF 2
jnz_not    2 08 01 08 0 1 0 1 0 2 A5 0 001 2
set_bcz2   1 02 00 00 0 1 0 1 0 2 A5 0 001 3
jovf_taken 2 0B 77 01 8 1 0 1 0 2 A5 0 377 3
jovf_not   2 0C 88 0C 0 1 0 1 0 2 A5 0 488 3
ill_grp2   1 15 00 00 0 1 0 1 0 2 A5 0 488 3
ill_grp3   1 1E 00 00 0 1 0 1 0 2 A5 0 488 3
ill_misc5  1 05 00 00 0 1 0 1 0 2 A5 0 488 3
ill_misc6  1 06 00 00 0 1 0 1 0 2 A5 0 488 3
ill_misc7  1 07 00 00 0 1 0 1 0 2 A5 0 488 3
nop        1 00 00 00 0 1 0 1 0 2 A5 0 488 3
halt       1 01 00 00 0 1 0 1 0 2 A5 0 488 3

//--- vlog.f
+incdir+verilog
verilog/idecode_pkg.sv
verilog/inst_assembler.sv
verilog/op_decoder.sv
verilog/idecode_top.sv
sim/idecode_checker.sv
sim/idecode_tb.sv

//--- run_sim.sh
#!/bin/sh
# build and run the decode testbench with verilator
cd "$(dirname "$0")" \
    && verilator --binary --assert --top-module idecode_tb -f vlog.f -o idecode_sim \
    && ./obj_dir/idecode_sim +verilator+error+limit+100 \
        | tee /dev/stderr | grep -q "Simulation completed successfully" \
    && echo "run passed" \
    || { echo "run failed"; exit 1; }
